/* hw/rfv_pkg.sv */
// Sizes and types shared by the register-valid scoreboard. Widths follow the sizes here,
// but the slot selector assumes at most three slots and a queue of at most eight entries.
package rfv_pkg;

	// ============================================================
	// Core sizes
	// ============================================================

	// Architectural registers tracked by the scoreboard
	localparam int AREGS = 128;
	// Bits in a register number
	localparam int RBITS = 7;
	// Issue-queue entries and the tag width that names one
	localparam int QENTRIES = 8;
	localparam int QBITS = 3;
	// Slots in one fetch group
	localparam int QSLOTS = 3;
	// Widest group the queue may take in a single cycle
	localparam int WAYS = 3;
	// Commit ports returning results
	localparam int NUM_CMT = 2;

	// Registers that always read as valid, whatever is queued or committed
	localparam int R_ZERO = 0;
	localparam int R_HALF = 64;

	// ============================================================
	// Types
	// ============================================================

	// Register number
	typedef logic [RBITS-1:0] reg_idx_t;

	// Issue-queue entry tag
	typedef logic [QBITS-1:0] qtag_t;

	// One bit per slot, bit 0 is the oldest slot of the group
	typedef logic [QSLOTS-1:0] slot_mask_t;

	// One bit per architectural register
	typedef logic [AREGS-1:0] reg_mask_t;

	// Number of slots the selector queues this cycle
	// The encoding equals the count, so a cast to int gives the slot count
	typedef enum logic [1:0] {
		Q_NONE  = 2'd0,
		Q_ONE   = 2'd1,
		Q_TWO   = 2'd2,
		Q_THREE = 2'd3
	} queue_mode_e;

endpackage

/* hw/rfv_slot_if.sv */
// Enqueue decisions for one fetch group, as combinational levels valid in the same cycle.
// Destination and tag entries are meaningful only where the matching inv_mask bit is set.
`timescale 1ns/1ns

interface rfv_slot_if;

	// Slots that invalidate their destination register this cycle
	rfv_pkg::slot_mask_t inv_mask;

	// Destination register of each slot, entry 0 belongs to the oldest slot
	rfv_pkg::reg_idx_t [rfv_pkg::QSLOTS-1:0] inv_rd;

	// Queue tag each slot is written to, which becomes the register's producer
	rfv_pkg::qtag_t [rfv_pkg::QSLOTS-1:0] inv_tag;

	// How many slots were queued in total, with or without a destination write
	rfv_pkg::queue_mode_e mode;

	// Slot selector side, it produces every decision
	modport sel (
		output inv_mask,
		output inv_rd,
		output inv_tag,
		output mode
	);

	// Scoreboard side, it only consumes the decisions
	modport sb (
		input inv_mask,
		input inv_rd,
		input inv_tag,
		input mode
	);

endinterface

/* hw/enqueue_slot_select.sv */
// Picks the slots of a fetch group that enter the issue queue this cycle.
// The canq levels are taken as nested, a wider level implies the narrower ones.
`timescale 1ns/1ns

module enqueue_slot_select (
	input  logic                                   clk,
	input  rfv_pkg::slot_mask_t                    slotv,
	input  rfv_pkg::slot_mask_t                    slot_rfw,
	input  rfv_pkg::slot_mask_t                    slot_jc,
	input  rfv_pkg::slot_mask_t                    take_branch,
	input  rfv_pkg::slot_mask_t                    ip_mask,
	input  logic                                   phit,
	input  logic                                   canq1,
	input  logic                                   canq2,
	input  logic                                   canq3,
	input  logic                                   debug_on,
	input  logic                                   branchmiss,
	input  rfv_pkg::reg_idx_t [rfv_pkg::QSLOTS-1:0] rd,
	input  rfv_pkg::qtag_t    [rfv_pkg::QSLOTS-1:0] tail,
	rfv_slot_if.sel                                slots
);

	// ============================================================
	// Group width
	// ============================================================

	// Slots that hold a live instruction this cycle
	rfv_pkg::slot_mask_t active;
	// Widest group the queue accepts right now
	logic [1:0] limit;
	// Slots actually queued, in fetch order
	rfv_pkg::slot_mask_t queued;
	// Number of slots queued so far while walking the group
	logic [1:0] taken;
	// Set once a control-flow slot has closed the group
	logic stop;

	// A slot only counts when the fetch hit and the slot is not masked off
	assign active = slotv & ip_mask & {rfv_pkg::QSLOTS{phit}};

	// Debug mode steps one instruction at a time, so only the single-slot level applies
	always_comb begin
		if (canq3 && !debug_on && rfv_pkg::WAYS > 2) begin
			limit = 2'd3;
		end else if (canq2 && !debug_on && rfv_pkg::WAYS > 1) begin
			limit = 2'd2;
		end else if (canq1) begin
			limit = 2'd1;
		end else begin
			limit = 2'd0;
		end
	end

	// ============================================================
	// Slot walk
	// ============================================================

	// Take active slots oldest first until the width runs out
	// A jump-and-call or a taken branch is queued itself but ends the group,
	// since the slots after it lie on the wrong path
	always_comb begin
		queued = '0;
		taken = 2'd0;
		stop = 1'b0;
		for (int i = 0; i < rfv_pkg::QSLOTS; i++) begin
			if (active[i] && !stop && taken < limit) begin
				queued[i] = 1'b1;
				taken = taken + 2'd1;
				if (slot_jc[i] || take_branch[i]) begin
					stop = 1'b1;
				end
			end
		end
	end

	// ============================================================
	// Decisions to the scoreboard
	// ============================================================

	// Nothing enters the queue while a branch miss is flushing it
	always_comb begin
		slots.inv_mask = '0;
		slots.mode = rfv_pkg::Q_NONE;
		if (!branchmiss) begin
			// Only queued slots that write a register take it out of the valid set
			slots.inv_mask = queued & slot_rfw;
			slots.mode = rfv_pkg::queue_mode_e'(taken);
		end
	end

	// Destination and tag ride along unchanged, the mask says which entries count
	assign slots.inv_rd = rd;
	assign slots.inv_tag = tail;

	// A group never invalidates more registers than it has slots queued
	a_mask_within_mode: assert property (
		@(posedge clk) $countones(slots.inv_mask) <= int'(slots.mode)
	) else $error("inv_mask holds more slots than the queued width");

endmodule

/* hw/commit_validate.sv */
// Decides whether each commit port may mark its target register valid again.
// Port 1 only ever acts when port 0 does not, so at most one register revalidates per cycle.
`timescale 1ns/1ns

module commit_validate (
	input  logic                                  clk,
	input  logic                                  commit0_v,
	input  logic                                  commit1_v,
	input  rfv_pkg::qtag_t                        commit0_id,
	input  rfv_pkg::qtag_t                        commit1_id,
	input  rfv_pkg::reg_idx_t                     commit0_tgt,
	input  rfv_pkg::reg_idx_t                     commit1_tgt,
	input  logic                                  branchmiss,
	input  logic [rfv_pkg::QENTRIES-1:0]          iq_source,
	input  rfv_pkg::reg_mask_t                    rf_v,
	input  rfv_pkg::qtag_t [rfv_pkg::AREGS-1:0]   rf_source,
	output logic                                  set0,
	output logic                                  set1,
	output rfv_pkg::reg_idx_t                     tgt0,
	output rfv_pkg::reg_idx_t                     tgt1
);

	// ============================================================
	// Producer match
	// ============================================================

	// The register may have been renamed to a newer producer after the result
	// went onto the commit bus, so the recorded tag must still name this entry
	logic tag_hit0;
	logic tag_hit1;

	// During a branch miss the producer may be flushed, in which case nothing
	// newer will ever write the register and the commit is allowed through
	logic flush_hit0;
	logic flush_hit1;

	// Port carries a result for a register still waiting on it
	logic want0;
	logic want1;

	assign tag_hit0 = rf_source[commit0_tgt] == commit0_id;
	assign tag_hit1 = rf_source[commit1_tgt] == commit1_id;

	assign flush_hit0 = branchmiss && iq_source[commit0_id];
	assign flush_hit1 = branchmiss && iq_source[commit1_id];

	// A register already valid has nothing to wait for
	assign want0 = commit0_v && !rf_v[commit0_tgt];
	assign want1 = commit1_v && !rf_v[commit1_tgt];

	// ============================================================
	// Port decisions
	// ============================================================

	assign set0 = want0 && (tag_hit0 || flush_hit0);

	// Port 1 yields whenever port 0 revalidates, whatever register port 0 targets
	// A single-port build never drives it
	assign set1 = (rfv_pkg::NUM_CMT > 1) && want1 && (tag_hit1 || flush_hit1) && !set0;

	assign tgt0 = commit0_tgt;
	assign tgt1 = commit1_tgt;

	// A revalidation on port 0 always comes from a commit strobe on that port
	a_set0_needs_commit: assert property (
		@(posedge clk) $rose(set0) |-> commit0_v
	) else $error("set0 rose without commit0_v");

endmodule

/* hw/regfile_valid.sv */
// Valid bits and producer tags of the architectural registers, updated once per clock.
// Enqueue is ignored during a branch miss, and registers 0 and 64 always read valid.
`timescale 1ns/1ns

module regfile_valid (
	input  logic                                  clk,
	input  logic                                  rst,
	input  logic                                  branchmiss,
	input  rfv_pkg::reg_mask_t                    livetarget,
	input  logic                                  set0,
	input  logic                                  set1,
	input  rfv_pkg::reg_idx_t                     tgt0,
	input  rfv_pkg::reg_idx_t                     tgt1,
	rfv_slot_if.sb                                slots,
	output rfv_pkg::reg_mask_t                    rf_v,
	output rfv_pkg::qtag_t [rfv_pkg::AREGS-1:0]   rf_source
);

	// Next-state values built by the merge below
	rfv_pkg::reg_mask_t rf_v_nxt;
	rfv_pkg::qtag_t [rfv_pkg::AREGS-1:0] src_nxt;

	// Enqueue takes part only outside a branch miss and when some slot was queued
	logic enq_en;

	assign enq_en = !branchmiss && (slots.mode != rfv_pkg::Q_NONE);

	// ============================================================
	// Update merge
	// ============================================================

	// The steps run in priority order and each later step overrides the earlier ones
	always_comb begin
		rf_v_nxt = rf_v;
		src_nxt = rf_source;

		// Registers no surviving instruction targets have nothing pending any more
		if (branchmiss) begin
			rf_v_nxt = rf_v | ~livetarget;
		end

		// Commit results only ever set bits, the validator already checked the tag
		if (set0) begin
			rf_v_nxt[tgt0] = 1'b1;
		end
		if (set1) begin
			rf_v_nxt[tgt1] = 1'b1;
		end

		// A newly queued writer wins over a commit to the same register
		// Slots are walked oldest first so a younger writer of the same register
		// leaves its own tag in the table
		if (enq_en) begin
			for (int i = 0; i < rfv_pkg::QSLOTS; i++) begin
				if (slots.inv_mask[i]) begin
					rf_v_nxt[slots.inv_rd[i]] = 1'b0;
					src_nxt[slots.inv_rd[i]] = slots.inv_tag[i];
				end
			end
		end

		// These two registers are hardwired and can never be waited on
		rf_v_nxt[rfv_pkg::R_ZERO] = 1'b1;
		rf_v_nxt[rfv_pkg::R_HALF] = 1'b1;
	end

	// ============================================================
	// State
	// ============================================================

	// Out of reset every register is valid and no producer is recorded
	always_ff @(posedge clk) begin
		if (rst) begin
			rf_v <= '1;
			rf_source <= '0;
		end else begin
			rf_v <= rf_v_nxt;
			rf_source <= src_nxt;
		end
	end

	// The hardwired registers hold valid through every kind of update
	a_fixed_regs_valid: assert property (
		@(posedge clk) !rst |=> (rf_v[rfv_pkg::R_ZERO] && rf_v[rfv_pkg::R_HALF])
	) else $error("register 0 or 64 read as invalid");

endmodule

/* hw/rfv_top.sv */
// Register-valid scoreboard with plain ports; every input reaches rf_v one clock later.
// rf_source packs the tag of register n into bits 3n+2 down to 3n.
`timescale 1ns/1ns

module rfv_top (
	input  logic                                        clk,
	input  logic                                        rst,
	input  logic                                        phit,
	input  rfv_pkg::slot_mask_t                         ip_mask,
	input  rfv_pkg::slot_mask_t                         slotv,
	input  rfv_pkg::slot_mask_t                         slot_rfw,
	input  rfv_pkg::slot_mask_t                         slot_jc,
	input  rfv_pkg::slot_mask_t                         take_branch,
	input  rfv_pkg::reg_idx_t                           rd0,
	input  rfv_pkg::reg_idx_t                           rd1,
	input  rfv_pkg::reg_idx_t                           rd2,
	input  rfv_pkg::qtag_t                              tail0,
	input  rfv_pkg::qtag_t                              tail1,
	input  rfv_pkg::qtag_t                              tail2,
	input  logic                                        canq1,
	input  logic                                        canq2,
	input  logic                                        canq3,
	input  logic                                        debug_on,
	input  logic                                        branchmiss,
	input  rfv_pkg::reg_mask_t                          livetarget,
	input  logic [rfv_pkg::QENTRIES-1:0]                iq_source,
	input  logic                                        commit0_v,
	input  logic                                        commit1_v,
	input  rfv_pkg::qtag_t                              commit0_id,
	input  rfv_pkg::qtag_t                              commit1_id,
	input  rfv_pkg::reg_idx_t                           commit0_tgt,
	input  rfv_pkg::reg_idx_t                           commit1_tgt,
	output rfv_pkg::reg_mask_t                          rf_v,
	output logic [rfv_pkg::AREGS*rfv_pkg::QBITS-1:0]    rf_source
);

	// ============================================================
	// Internal connections
	// ============================================================

	// Producer tag table as held by the scoreboard
	rfv_pkg::qtag_t [rfv_pkg::AREGS-1:0] src_tab;

	// Commit decisions into the scoreboard
	logic set0;
	logic set1;
	rfv_pkg::reg_idx_t tgt0;
	rfv_pkg::reg_idx_t tgt1;

	rfv_slot_if slots ();

	assign rf_source = src_tab;

	// Slot selector, per-slot fields packed with slot 0 in the low entry
	enqueue_slot_select u_sel (
		.clk         (clk),
		.slotv       (slotv),
		.slot_rfw    (slot_rfw),
		.slot_jc     (slot_jc),
		.take_branch (take_branch),
		.ip_mask     (ip_mask),
		.phit        (phit),
		.canq1       (canq1),
		.canq2       (canq2),
		.canq3       (canq3),
		.debug_on    (debug_on),
		.branchmiss  (branchmiss),
		.rd          ({rd2, rd1, rd0}),
		.tail        ({tail2, tail1, tail0}),
		.slots       (slots.sel)
	);

	// Commit validator, reads the current table and valid bits
	commit_validate u_cmt (
		.clk         (clk),
		.commit0_v   (commit0_v),
		.commit1_v   (commit1_v),
		.commit0_id  (commit0_id),
		.commit1_id  (commit1_id),
		.commit0_tgt (commit0_tgt),
		.commit1_tgt (commit1_tgt),
		.branchmiss  (branchmiss),
		.iq_source   (iq_source),
		.rf_v        (rf_v),
		.rf_source   (src_tab),
		.set0        (set0),
		.set1        (set1),
		.tgt0        (tgt0),
		.tgt1        (tgt1)
	);

	// Scoreboard state
	regfile_valid u_rfv (
		.clk         (clk),
		.rst         (rst),
		.branchmiss  (branchmiss),
		.livetarget  (livetarget),
		.set0        (set0),
		.set1        (set1),
		.tgt0        (tgt0),
		.tgt1        (tgt1),
		.slots       (slots.sb),
		.rf_v        (rf_v),
		.rf_source   (src_tab)
	);

endmodule

/* tests/rfv_tb.sv */
// Directed testbench for the register-valid scoreboard. Inputs change on the falling edge.
// The expected valid bits and tags come from a model kept here and updated per test.
`timescale 1ns/1ns

module rfv_tb;

	// ============================================================
	// DUT signals and model state
	// ============================================================

	logic clk;
	logic rst;
	logic phit, canq1, canq2, canq3, debug_on, branchmiss;
	logic commit0_v, commit1_v;
	rfv_pkg::slot_mask_t ip_mask, slotv, slot_rfw, slot_jc, take_branch;
	rfv_pkg::reg_idx_t rd0, rd1, rd2, commit0_tgt, commit1_tgt;
	rfv_pkg::qtag_t tail0, tail1, tail2, commit0_id, commit1_id;
	rfv_pkg::reg_mask_t livetarget;
	logic [7:0] iq_source;
	rfv_pkg::reg_mask_t rf_v;
	logic [383:0] rf_source;

	// Expected valid bits and producer tags
	rfv_pkg::reg_mask_t exp_v;
	rfv_pkg::qtag_t [127:0] exp_src;
	int errors;
	int checks;
	integer seed;

	rfv_top rfv_top_inst (.*);

	// 40 ns period
	always #20 clk = ~clk;

	// ============================================================
	// Helpers
	// ============================================================

	task automatic compare_value(input string what, input logic [383:0] got,
			input logic [383:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("ERR %0t: %s mismatch, got %h expected %h", $time, what, got, exp);
		end
	endtask

	// Nothing fetched and nothing committed, but the fetch path is open
	task automatic drive_idle();
		phit = 1'b1;
		ip_mask = 3'b111;
		{slotv, slot_rfw, slot_jc, take_branch} = '0;
		{canq1, canq2, canq3, debug_on, branchmiss} = '0;
		{rd0, rd1, rd2, tail0, tail1, tail2} = '0;
		{commit0_v, commit1_v, commit0_id, commit1_id, commit0_tgt, commit1_tgt} = '0;
		livetarget = '0;
		iq_source = '0;
	endtask

	task automatic drive_slot(input int i, input rfv_pkg::reg_idx_t r, input rfv_pkg::qtag_t tag,
			input logic rfw);
		slotv[i] = 1'b1;
		slot_rfw[i] = rfw;
		case (i)
			0: begin
				rd0 = r;
				tail0 = tag;
			end
			1: begin
				rd1 = r;
				tail1 = tag;
			end
			default: begin
				rd2 = r;
				tail2 = tag;
			end
		endcase
	endtask

	// Three register-writing slots on consecutive registers and tags
	task automatic drive_group(input rfv_pkg::reg_idx_t base, input rfv_pkg::qtag_t tag);
		for (int i = 0; i < 3; i++) begin
			drive_slot(i, base + 7'(i), tag + 3'(i), 1'b1);
		end
	endtask

	// A queued writer records its tag, and only registers 0 and 64 stay valid
	function automatic void expect_write(input rfv_pkg::reg_idx_t r, input rfv_pkg::qtag_t tag);
		exp_src[r] = tag;
		if (r != 7'd0 && r != 7'd64) begin
			exp_v[r] = 1'b0;
		end
	endfunction

	function automatic rfv_pkg::reg_idx_t pick_reg();
		rfv_pkg::reg_idx_t r;
		r = rfv_pkg::reg_idx_t'($random(seed));
		if (r == 7'd0 || r == 7'd64) begin
			r = r + 7'd1;
		end
		return r;
	endfunction

	// Every update shows one rising edge later and is checked at the following falling edge
	task automatic step_and_check(input string what);
		@(posedge clk);
		@(negedge clk);
		compare_value({what, " rf_v"}, 384'(rf_v), 384'(exp_v));
		compare_value({what, " rf_source"}, rf_source, exp_src);
		drive_idle();
	endtask

	// ============================================================
	// Directed tests
	// ============================================================

	task automatic test_reset();
		compare_value("reset rf_v", 384'(rf_v), 384'(exp_v));
		compare_value("reset rf_source", rf_source, exp_src);
	endtask

	task automatic test_single_enqueue();
		rfv_pkg::reg_idx_t r;
		r = pick_reg();
		canq1 = 1'b1;
		drive_slot(0, r, 3'd5, 1'b1);
		expect_write(r, 3'd5);
		step_and_check("single writer");
		// Without a register write the slot leaves the table alone
		canq1 = 1'b1;
		drive_slot(0, pick_reg(), 3'd1, 1'b0);
		step_and_check("slot without rfw");
		canq1 = 1'b1;
		drive_slot(0, 7'd0, 3'd6, 1'b1);
		expect_write(7'd0, 3'd6);
		step_and_check("write to register 0");
		canq1 = 1'b1;
		drive_slot(0, 7'd64, 3'd7, 1'b1);
		expect_write(7'd64, 3'd7);
		step_and_check("write to register 64");
	endtask

	task automatic test_group_width();
		{canq1, canq2} = 2'b11;
		drive_group(7'd10, 3'd1);
		expect_write(7'd10, 3'd1);
		expect_write(7'd11, 3'd2);
		step_and_check("two-wide group");
		{canq1, canq2, canq3} = 3'b111;
		drive_group(7'd20, 3'd4);
		expect_write(7'd20, 3'd4);
		expect_write(7'd21, 3'd5);
		expect_write(7'd22, 3'd6);
		step_and_check("three-wide group");
		// The jump-and-call itself is queued but the slot after it is not
		{canq1, canq2, canq3} = 3'b111;
		drive_group(7'd30, 3'd1);
		slot_jc = 3'b010;
		expect_write(7'd30, 3'd1);
		expect_write(7'd31, 3'd2);
		step_and_check("group cut by jump-and-call");
		{canq1, canq2, canq3} = 3'b111;
		drive_group(7'd33, 3'd1);
		take_branch = 3'b001;
		expect_write(7'd33, 3'd1);
		step_and_check("group cut by taken branch");
		{canq1, canq2, canq3, debug_on} = 4'b1111;
		drive_group(7'd36, 3'd1);
		expect_write(7'd36, 3'd1);
		step_and_check("debug single step");
		{canq1, canq2, canq3} = 3'b111;
		drive_group(7'd40, 3'd1);
		ip_mask = 3'b010;
		expect_write(7'd41, 3'd2);
		step_and_check("partly masked group");
		{canq1, canq2, canq3} = 3'b111;
		drive_group(7'd43, 3'd1);
		ip_mask = 3'b000;
		step_and_check("fully masked group");
		{canq1, canq2, canq3} = 3'b111;
		drive_group(7'd46, 3'd1);
		phit = 1'b0;
		step_and_check("fetch miss");
	endtask

	task automatic test_commit();
		canq1 = 1'b1;
		drive_slot(0, 7'd50, 3'd4, 1'b1);
		expect_write(7'd50, 3'd4);
		step_and_check("writer of r50");
		{commit0_v, commit0_id, commit0_tgt} = {1'b1, 3'd4, 7'd50};
		exp_v[50] = 1'b1;
		step_and_check("matching commit");
		canq1 = 1'b1;
		drive_slot(0, 7'd51, 3'd2, 1'b1);
		expect_write(7'd51, 3'd2);
		step_and_check("writer of r51");
		{commit0_v, commit0_id, commit0_tgt} = {1'b1, 3'd3, 7'd51};
		step_and_check("stale commit");
		{canq1, canq2} = 2'b11;
		drive_slot(0, 7'd52, 3'd5, 1'b1);
		drive_slot(1, 7'd53, 3'd6, 1'b1);
		expect_write(7'd52, 3'd5);
		expect_write(7'd53, 3'd6);
		step_and_check("writers of r52 and r53");
		// Port 1 yields to port 0 even on a different register
		{commit0_v, commit0_id, commit0_tgt} = {1'b1, 3'd5, 7'd52};
		{commit1_v, commit1_id, commit1_tgt} = {1'b1, 3'd6, 7'd53};
		exp_v[52] = 1'b1;
		step_and_check("dual commit");
		{commit1_v, commit1_id, commit1_tgt} = {1'b1, 3'd6, 7'd53};
		exp_v[53] = 1'b1;
		step_and_check("port 1 commit alone");
	endtask

	task automatic test_branch_miss();
		rfv_pkg::reg_mask_t live;
		live = '0;
		live[60] = 1'b1;
		live[61] = 1'b1;
		{canq1, canq2} = 2'b11;
		drive_slot(0, 7'd60, 3'd1, 1'b1);
		drive_slot(1, 7'd61, 3'd2, 1'b1);
		expect_write(7'd60, 3'd1);
		expect_write(7'd61, 3'd2);
		step_and_check("writers before branch miss");
		// The enqueue to r62 must leave neither a tag nor an invalid bit
		{branchmiss, canq1} = 2'b11;
		livetarget = live;
		drive_slot(0, 7'd62, 3'd3, 1'b1);
		exp_v = exp_v | ~live;
		step_and_check("branch miss revalidation");
		branchmiss = 1'b1;
		livetarget = live;
		iq_source = 8'h80;
		{commit0_v, commit0_id, commit0_tgt} = {1'b1, 3'd7, 7'd60};
		exp_v[60] = 1'b1;
		step_and_check("commit of flushed producer");
	endtask

	task automatic test_same_edge();
		// r61 waits on tag 2 and the new writer must win over the matching commit
		{commit0_v, commit0_id, commit0_tgt} = {1'b1, 3'd2, 7'd61};
		canq1 = 1'b1;
		drive_slot(0, 7'd61, 3'd4, 1'b1);
		expect_write(7'd61, 3'd4);
		step_and_check("commit and enqueue on one register");
		{commit0_v, commit0_id, commit0_tgt} = {1'b1, 3'd4, 7'd61};
		exp_v[61] = 1'b1;
		step_and_check("commit of the new writer");
	endtask

	// ============================================================
	// Sequence
	// ============================================================

	initial begin
		seed = 32'hf85d;
		errors = 0;
		checks = 0;
		clk = 1'b0;
		rst = 1'b1;
		drive_idle();
		exp_v = '1;
		exp_src = '0;
		for (int n = 0; n < 8; n++) begin
			@(posedge clk);
		end
		@(negedge clk);
		rst = 1'b0;
		// Reset state is already in place, no edge has passed since release
		test_reset();
		test_single_enqueue();
		test_group_width();
		test_commit();
		test_branch_miss();
		test_same_edge();
		$display("checks %0d, errors %0d", checks, errors);
		if (errors == 0) begin
			$display("test passed");
		end else begin
			$display("test failed");
		end
		$finish;
	end

endmodule

/* rf_valid_track.f */
hw/rfv_pkg.sv
hw/rfv_slot_if.sv
hw/enqueue_slot_select.sv
hw/commit_validate.sv
hw/regfile_valid.sv
hw/rfv_top.sv
tests/rfv_tb.sv

/* Makefile */
# Verilator build and run of the register-valid scoreboard testbench

VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       := rfv_tb
FILELIST  := rf_valid_track.f
OBJ_DIR   := obj_dir
SIM_BIN   := $(OBJ_DIR)/V$(TOP)
SIM_LOG   := sim.log
SOURCES   := $(wildcard hw/*.sv tests/*.sv)

.PHONY: all run clean

all: run

# Rebuilt only when a source or the file list changes
$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# The run fails unless the log holds the pass line
run: $(SIM_BIN)
	./$(SIM_BIN) | tee $(SIM_LOG)
	grep -q "^test passed$$" $(SIM_LOG)

clean:
	rm -rf $(OBJ_DIR) $(SIM_LOG)
